// File: saturnGlue.f
+incdir+source
source/saturnPkg.sv
source/cpuBusRouter.sv
source/peripheralBusMux.sv
source/resetClockControl.sv
source/saturnGlue.sv
tests/saturnGlue_asserts.sv
tests/saturnGlueTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module saturnGlueTb -f saturnGlue.f
./obj_dir/VsaturnGlueTb > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log || ! grep -q "Done: no errors" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

// File: tests/saturnGlueTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "saturnGlue_defs.svh"

module saturnGlueTb import saturnPkg::*;;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 3;
	localparam int HOLD_CYCLES = 4;
	localparam int PROBE_CYCLES = 8;
	localparam int RANDOM_CYCLES = 400;
	localparam int TOTAL_CYCLES = RESET_CYCLES + HOLD_CYCLES + PROBE_CYCLES + RANDOM_CYCLES + 1;
	localparam int WATCHDOG_NS = 2 * TOTAL_CYCLES * CLK_PERIOD;

	typedef struct packed {
		memPort_t memSel;
		cpuAddr_t memA;
		cpuData_t memDo;
		cpuData_t cpuDi;
		logic     cpuWaitN;
		logic     ramhRfs;
	} cpuSideOut_t;

	typedef struct packed {
		busWord_t aDi;
		busWord_t bDi;
		logic     aWaitN;
	} busSideOut_t;

	typedef struct packed {
		logic mresN;
		logic scspResN;
		logic scpuResN;
		logic shCeR;
		logic shCeF;
	} ctlSideOut_t;

	typedef struct packed {
		cpuSideOut_t cpu;
		busSideOut_t bus;
		ctlSideOut_t ctl;
	} glueOut_t;

	logic       CLK = 1'b0;
	logic       RST_N;
	logic       SYS_CE_R;
	logic       SMPC_CE;
	logic       CD_CE;
	cpuBusReq_t cpuReq;
	dccSelect_t dccSel;
	cpuData_t   memDi;
	logic       MEM_WAIT_N;
	logic       scuWaitN;
	cpuData_t   scuDo;
	logic [7:0] smpcDo;
	cartMode_t  cartMode;
	logic       msRfs;
	logic       ecRfs;
	memPort_t   memSel;
	cpuAddr_t   memA;
	cpuData_t   memDo;
	cpuData_t   cpuDi;
	logic       cpuWaitN;
	logic       ramhRfs;
	aBusSel_t   aSel;
	busWord_t   cartDo;
	busWord_t   cdDo;
	logic       cartWaitN;
	logic       cdWaitN;
	bBusSel_t   bSel;
	busWord_t   vdp1Do;
	busWord_t   vdp2Do;
	busWord_t   scspDo;
	busWord_t   aDi;
	busWord_t   bDi;
	logic       aWaitN;
	smpcPort_t  pdr2o;
	smpcPort_t  ddr2;
	logic       sysResN;
	logic       sndResN;
	logic       mresN;
	logic       scspResN;
	logic       scpuResN;
	logic       shCeR;
	logic       shCeF;

	glueOut_t    actual;
	glueOut_t    expected;
	logic [15:0] lfsrState;
	logic        mresModel;
	logic        scspModel;
	logic        scpuModel;
	logic        cdPhaseModel;
	int          errors;
	int          checks;

	saturnGlue uut (.*);

	assign actual = {memSel, memA, memDo, cpuDi, cpuWaitN, ramhRfs, aDi, bDi, aWaitN,
		mresN, scspResN, scpuResN, shCeR, shCeF};

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsrNext(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	task automatic drawBits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = lfsrNext(lfsrState);
			value = {value[30:0], lfsrState[0]};
		end
	endtask

	// Expected registers of the reset and clock-enable logic
	always @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			mresModel <= 1'b0;
			scspModel <= 1'b0;
			scpuModel <= 1'b0;
			cdPhaseModel <= 1'b0;
		end else begin
			if (SMPC_CE) begin
				mresModel <= 1'b1;
			end
			if (SYS_CE_R) begin
				scspModel <= ddr2[`STV_SCSP_BIT] && !pdr2o[`STV_SCSP_BIT];
				scpuModel <= ddr2[`STV_SCPU_BIT] && !pdr2o[`STV_SCPU_BIT];
			end
			if (CD_CE) begin
				cdPhaseModel <= !cdPhaseModel;
			end
		end
	end

	function automatic glueOut_t expectedOutputs();
		glueOut_t e;
		logic stvMode;
		logic stvSel;
		logic memSelected;
		stvMode = (cartMode == `STV_CART_MODE);
		stvSel = stvMode && !cpuReq.cs0N && cpuReq.addr >= `STV_IO_FIRST &&
			cpuReq.addr <= `STV_IO_LAST;
		memSelected = !(cpuReq.cs3N && dccSel.dramN && dccSel.romN && dccSel.sramN);
		e.cpu.memSel = {dccSel.romN, dccSel.sramN, dccSel.dramN, cpuReq.cs3N, !stvSel,
			cpuReq.dqmN, cpuReq.rdN};
		e.cpu.memA = cpuReq.addr;
		e.cpu.memDo = cpuReq.wrData;
		if (memSelected || stvSel) begin
			e.cpu.cpuDi = memDi;
		end else if (!dccSel.smpcN) begin
			e.cpu.cpuDi = {smpcDo, smpcDo, smpcDo, smpcDo};
		end else begin
			e.cpu.cpuDi = scuDo;
		end
		e.cpu.cpuWaitN = memSelected ? (scuWaitN && MEM_WAIT_N) : scuWaitN;
		e.cpu.ramhRfs = msRfs || ecRfs;
		if (aSel[1:0] != 2'b11) begin
			e.bus.aDi = cartDo;
		end else if (!aSel[2]) begin
			e.bus.aDi = cdDo;
		end else begin
			e.bus.aDi = `ABUS_IDLE_DATA;
		end
		if (!bSel[0]) begin
			e.bus.bDi = vdp1Do;
		end else if (!bSel[1]) begin
			e.bus.bDi = vdp2Do;
		end else if (!bSel[2]) begin
			e.bus.bDi = scspDo;
		end else begin
			e.bus.bDi = `BBUS_IDLE_DATA;
		end
		e.bus.aWaitN = cartWaitN && cdWaitN;
		e.ctl.mresN = mresModel;
		e.ctl.scspResN = stvMode ? scspModel : sysResN;
		e.ctl.scpuResN = stvMode ? scpuModel : sndResN;
		e.ctl.shCeR = CD_CE && cdPhaseModel;
		e.ctl.shCeF = CD_CE && !cdPhaseModel;
		return e;
	endfunction

	// Inputs settle 1 ns after the rising edge, so sample on the falling one
	always @(negedge CLK) begin
		expected = expectedOutputs();
		checks = checks + 3;
		assert (actual.cpu == expected.cpu) else begin
			errors++;
			$display("Fail %0t: CPU bus outputs %h, expected %h",
				$time, actual.cpu, expected.cpu);
		end
		assert (actual.bus == expected.bus) else begin
			errors++;
			$display("Fail %0t: A/B bus outputs %h, expected %h",
				$time, actual.bus, expected.bus);
		end
		assert (actual.ctl == expected.ctl) else begin
			errors++;
			$display("Fail %0t: reset and clock enables %b, expected %b",
				$time, actual.ctl, expected.ctl);
		end
	end

	task automatic nextCycle();
		@(posedge CLK);
		#1;
	endtask

	task automatic idleInputs();
		SYS_CE_R = 1'b0;
		SMPC_CE = 1'b0;
		CD_CE = 1'b0;
		cpuReq = '1;
		cpuReq.addr = '0;
		cpuReq.wrData = '0;
		dccSel = '1;
		memDi = '0;
		MEM_WAIT_N = 1'b1;
		scuWaitN = 1'b1;
		scuDo = '0;
		smpcDo = '0;
		cartMode = '0;
		msRfs = 1'b0;
		ecRfs = 1'b0;
		aSel = '1;
		bSel = '1;
		cartDo = '0;
		cdDo = '0;
		cartWaitN = 1'b1;
		cdWaitN = 1'b1;
		vdp1Do = '0;
		vdp2Do = '0;
		scspDo = '0;
		pdr2o = '0;
		ddr2 = '0;
		sysResN = 1'b1;
		sndResN = 1'b1;
	endtask

	task automatic randomizeInputs();
		logic [31:0] bits;
		cpuAddr_t    addrRandom;
		logic [6:0]  offset;
		drawBits(25, bits);
		addrRandom = bits[24:0];
		drawBits(7, bits);
		offset = bits[6:0];
		// Aim most addresses at or near the ST-V window
		drawBits(2, bits);
		case (bits[1:0])
			2'd0: cpuReq.addr = addrRandom;
			2'd1: cpuReq.addr = `STV_IO_FIRST + {18'd0, offset};
			2'd2: cpuReq.addr = `STV_IO_LAST + {18'd0, offset} + 25'd1;
			default: cpuReq.addr = `STV_IO_FIRST - {18'd0, offset} - 25'd1;
		endcase
		drawBits(32, bits);
		cpuReq.wrData = bits;
		drawBits(7, bits);
		cpuReq.cs0N = bits[0];
		cpuReq.cs3N = bits[1];
		cpuReq.dqmN = bits[5:2];
		cpuReq.rdN = bits[6];
		drawBits(4, bits);
		dccSel = bits[3:0];
		// Half the time no memory, so SMPC and SCU returns get exercised
		drawBits(1, bits);
		if (bits[0]) begin
			cpuReq.cs3N = 1'b1;
			dccSel.dramN = 1'b1;
			dccSel.romN = 1'b1;
			dccSel.sramN = 1'b1;
		end
		drawBits(32, bits);
		memDi = bits;
		drawBits(32, bits);
		scuDo = bits;
		drawBits(8, bits);
		smpcDo = bits[7:0];
		drawBits(4, bits);
		MEM_WAIT_N = bits[0];
		scuWaitN = bits[1];
		msRfs = bits[2];
		ecRfs = bits[3];
		drawBits(4, bits);
		cartMode = bits[0] ? `STV_CART_MODE : bits[3:1];
		drawBits(6, bits);
		aSel = bits[2:0];
		bSel = bits[5:3];
		drawBits(32, bits);
		cartDo = bits[15:0];
		cdDo = bits[31:16];
		drawBits(32, bits);
		vdp1Do = bits[15:0];
		vdp2Do = bits[31:16];
		drawBits(16, bits);
		scspDo = bits[15:0];
		drawBits(18, bits);
		pdr2o = bits[6:0];
		ddr2 = bits[13:7];
		cartWaitN = bits[14];
		cdWaitN = bits[15];
		sysResN = bits[16];
		sndResN = bits[17];
		drawBits(4, bits);
		SYS_CE_R = bits[0];
		CD_CE = bits[1];
		SMPC_CE = (bits[3:2] == 2'b00);
	endtask

	task automatic probeStvDecode(input cpuAddr_t addr, input cartMode_t mode);
		nextCycle();
		randomizeInputs();
		cpuReq.addr = addr;
		cpuReq.cs0N = 1'b0;
		cartMode = mode;
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the test did not finish within %0d ns", WATCHDOG_NS);
		$display("Done: errors found");
		$finish;
	end

	initial begin
		cartMode_t mode;
		lfsrState = 16'd54508;
		errors = 0;
		checks = 0;
		RST_N = 1'b0;
		idleInputs();
		repeat (RESET_CYCLES) @(posedge CLK);
		#1;
		RST_N = 1'b1;
		// Master reset must hold without an SMPC tick
		repeat (HOLD_CYCLES) begin
			nextCycle();
			randomizeInputs();
			SMPC_CE = 1'b0;
		end
		// Window edges and one past each, in and out of ST-V mode
		for (int m = 0; m < 2; m++) begin
			mode = (m == 0) ? `STV_CART_MODE : 3'd4;
			probeStvDecode(`STV_IO_FIRST - 25'd1, mode);
			probeStvDecode(`STV_IO_FIRST, mode);
			probeStvDecode(`STV_IO_LAST, mode);
			probeStvDecode(`STV_IO_LAST + 25'd1, mode);
		end
		repeat (RANDOM_CYCLES) begin
			nextCycle();
			randomizeInputs();
		end
		@(negedge CLK);
		#1;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/saturnGlue_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "saturnGlue_defs.svh"

module saturnGlueAsserts import saturnPkg::*; (
	input logic      CLK,
	input logic      RST_N,
	input cartMode_t cartMode,
	input memPort_t  memSel,
	input logic      mresN,
	input logic      shCeR,
	input logic      shCeF
);

	// Once released, master reset stays released
	mresHold: assert property (@(posedge CLK) disable iff (!RST_N) mresN |=> mresN)
		else $error("mresN fell after it was released");

	shCeExclusive: assert property (@(posedge CLK) !(shCeR && shCeF))
		else $error("shCeR and shCeF high in the same cycle");

	// ST-V I/O window exists on ST-V boards only
	stvModeOnly: assert property (@(posedge CLK)
		!memSel.stvIoN |-> cartMode == `STV_CART_MODE)
		else $error("ST-V I/O select active outside ST-V mode");

endmodule

bind saturnGlue saturnGlueAsserts assertChecks (
	.CLK(CLK), .RST_N(RST_N), .cartMode(cartMode), .memSel(memSel),
	.mresN(mresN), .shCeR(shCeR), .shCeF(shCeF)
);

`default_nettype wire

// File: source/saturnGlue.sv
`timescale 1ns/1ps
`default_nettype none

module saturnGlue import saturnPkg::*; (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       SYS_CE_R,
	input  logic       SMPC_CE,
	input  logic       CD_CE,
	// CPU bus side
	input  cpuBusReq_t cpuReq,
	input  dccSelect_t dccSel,
	input  cpuData_t   memDi,
	input  logic       MEM_WAIT_N,
	input  logic       scuWaitN,
	input  cpuData_t   scuDo,
	input  logic [7:0] smpcDo,
	input  cartMode_t  cartMode,
	input  logic       msRfs,
	input  logic       ecRfs,
	output memPort_t   memSel,
	output cpuAddr_t   memA,
	output cpuData_t   memDo,
	output cpuData_t   cpuDi,
	output logic       cpuWaitN,
	output logic       ramhRfs,
	// A-bus and B-bus
	input  aBusSel_t   aSel,
	input  busWord_t   cartDo,
	input  busWord_t   cdDo,
	input  logic       cartWaitN,
	input  logic       cdWaitN,
	input  bBusSel_t   bSel,
	input  busWord_t   vdp1Do,
	input  busWord_t   vdp2Do,
	input  busWord_t   scspDo,
	output busWord_t   aDi,
	output busWord_t   bDi,
	output logic       aWaitN,
	// Resets and clock enables
	input  smpcPort_t  pdr2o,
	input  smpcPort_t  ddr2,
	input  logic       sysResN,
	input  logic       sndResN,
	output logic       mresN,
	output logic       scspResN,
	output logic       scpuResN,
	output logic       shCeR,
	output logic       shCeF
);

	cpuBusRouter router (
		.cpuReq(cpuReq), .dccSel(dccSel), .memDi(memDi), .memWaitN(MEM_WAIT_N),
		.scuWaitN(scuWaitN), .scuDo(scuDo), .smpcDo(smpcDo), .cartMode(cartMode),
		.msRfs(msRfs), .ecRfs(ecRfs), .memSel(memSel), .memA(memA), .memDo(memDo),
		.cpuDi(cpuDi), .cpuWaitN(cpuWaitN), .ramhRfs(ramhRfs)
	);

	peripheralBusMux busMux (
		.aSel(aSel), .cartDo(cartDo), .cdDo(cdDo), .cartWaitN(cartWaitN),
		.cdWaitN(cdWaitN), .bSel(bSel), .vdp1Do(vdp1Do), .vdp2Do(vdp2Do),
		.scspDo(scspDo), .aDi(aDi), .bDi(bDi), .aWaitN(aWaitN)
	);

	resetClockControl resetCtl (
		.CLK(CLK), .RST_N(RST_N), .SYS_CE_R(SYS_CE_R), .SMPC_CE(SMPC_CE),
		.CD_CE(CD_CE), .cartMode(cartMode), .pdr2o(pdr2o), .ddr2(ddr2),
		.sysResN(sysResN), .sndResN(sndResN), .mresN(mresN), .scspResN(scspResN),
		.scpuResN(scpuResN), .shCeR(shCeR), .shCeF(shCeF)
	);

endmodule

`default_nettype wire

// File: source/resetClockControl.sv
`timescale 1ns/1ps
`default_nettype none

`include "saturnGlue_defs.svh"

module resetClockControl import saturnPkg::*; (
	input  logic      CLK,
	input  logic      RST_N,
	input  logic      SYS_CE_R,
	input  logic      SMPC_CE,
	input  logic      CD_CE,
	input  cartMode_t cartMode,
	input  smpcPort_t pdr2o,
	input  smpcPort_t ddr2,
	input  logic      sysResN,
	input  logic      sndResN,
	output logic      mresN,
	output logic      scspResN,
	output logic      scpuResN,
	output logic      shCeR,
	output logic      shCeF
);

	logic stvScspResN;
	logic stvScpuResN;
	logic cdPhase;
	logic stvMode;

	// Master reset released on first SMPC tick
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			mresN <= 1'b0;
		end else if (SMPC_CE) begin
			mresN <= 1'b1;
		end
	end

	// Released only while the port bit is an output driven low
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			stvScspResN <= 1'b0;
			stvScpuResN <= 1'b0;
		end else if (SYS_CE_R) begin
			stvScspResN <= ~(pdr2o[`STV_SCSP_BIT] | ~ddr2[`STV_SCSP_BIT]);
			stvScpuResN <= ~(pdr2o[`STV_SCPU_BIT] | ~ddr2[`STV_SCPU_BIT]);
		end
	end

	assign stvMode  = (cartMode == `STV_CART_MODE);
	assign scspResN = stvMode ? stvScspResN : sysResN;
	assign scpuResN = stvMode ? stvScpuResN : sndResN;

	// Halve CD_CE into rise and fall enables for the SH-1
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cdPhase <= 1'b0;
		end else if (CD_CE) begin
			cdPhase <= ~cdPhase;
		end
	end

	assign shCeR = cdPhase & CD_CE;
	assign shCeF = ~cdPhase & CD_CE;

endmodule

`default_nettype wire

// File: source/peripheralBusMux.sv
`timescale 1ns/1ps
`default_nettype none

`include "saturnGlue_defs.svh"

module peripheralBusMux import saturnPkg::*; (
	input  aBusSel_t aSel,
	input  busWord_t cartDo,
	input  busWord_t cdDo,
	input  logic     cartWaitN,
	input  logic     cdWaitN,
	input  bBusSel_t bSel,
	input  busWord_t vdp1Do,
	input  busWord_t vdp2Do,
	input  busWord_t scspDo,
	output busWord_t aDi,
	output busWord_t bDi,
	output logic     aWaitN
);

	// A-bus: CS0/CS1 cartridge, CS2 CD block
	always_comb begin
		if (!aSel[0] || !aSel[1]) begin
			aDi = cartDo;
		end else if (!aSel[2]) begin
			aDi = cdDo;
		end else begin
			aDi = `ABUS_IDLE_DATA;
		end
	end

	assign aWaitN = cartWaitN & cdWaitN;

	// B-bus select order: VDP1, VDP2, SCSP
	always_comb begin
		if (!bSel[0]) begin
			bDi = vdp1Do;
		end else if (!bSel[1]) begin
			bDi = vdp2Do;
		end else if (!bSel[2]) begin
			bDi = scspDo;
		end else begin
			bDi = `BBUS_IDLE_DATA;
		end
	end

endmodule

`default_nettype wire

// File: source/cpuBusRouter.sv
`timescale 1ns/1ps
`default_nettype none

`include "saturnGlue_defs.svh"

module cpuBusRouter import saturnPkg::*; (
	input  cpuBusReq_t cpuReq,
	input  dccSelect_t dccSel,
	input  cpuData_t   memDi,
	input  logic       memWaitN,
	input  logic       scuWaitN,
	input  cpuData_t   scuDo,
	input  logic [7:0] smpcDo,
	input  cartMode_t  cartMode,
	input  logic       msRfs,
	input  logic       ecRfs,
	output memPort_t   memSel,
	output cpuAddr_t   memA,
	output cpuData_t   memDo,
	output cpuData_t   cpuDi,
	output logic       cpuWaitN,
	output logic       ramhRfs
);

	logic stvIoHit;
	logic memHit;
	logic inStvWindow;

	// ST-V I/O lives in the CS0 area on ST-V boards only
	assign inStvWindow = (cpuReq.addr >= `STV_IO_FIRST) &&
		(cpuReq.addr <= `STV_IO_LAST);
	assign stvIoHit = inStvWindow && !cpuReq.cs0N &&
		(cartMode == `STV_CART_MODE);

	// RAMH sits on CS3, the rest come from the DCC
	assign memHit = !cpuReq.cs3N || !dccSel.dramN || !dccSel.romN || !dccSel.sramN;

	always_comb begin
		memSel.romN   = dccSel.romN;
		memSel.sramN  = dccSel.sramN;
		memSel.ramlN  = dccSel.dramN;
		memSel.ramhN  = cpuReq.cs3N;
		memSel.stvIoN = ~stvIoHit;
		memSel.dqmN   = cpuReq.dqmN;
		memSel.rdN    = cpuReq.rdN;
	end

	assign memA  = cpuReq.addr;
	assign memDo = cpuReq.wrData;

	// Read return priority
	always_comb begin
		if (memHit || stvIoHit) begin
			cpuDi = memDi;
		end else if (!dccSel.smpcN) begin
			// SMPC is byte wide, mirrored on all lanes
			cpuDi = {4{smpcDo}};
		end else begin
			cpuDi = scuDo;
		end
	end

	// Memory wait ignored unless a memory is selected
	assign cpuWaitN = scuWaitN & (memWaitN | ~memHit);

	// Refresh from master CPU or SCU
	assign ramhRfs = msRfs | ecRfs;

endmodule

`default_nettype wire

// File: source/saturnPkg.sv
`default_nettype none

`include "saturnGlue_defs.svh"

package saturnPkg;

	typedef logic [`CPU_ADDR_W-1:0]  cpuAddr_t;
	typedef logic [`CPU_DATA_W-1:0]  cpuData_t;
	typedef logic [`PBUS_DATA_W-1:0] busWord_t;
	typedef logic [2:0]              cartMode_t;
	typedef logic [6:0]              smpcPort_t;

	// Master CPU bus request, strobes active low
	typedef struct packed {
		cpuAddr_t   addr;
		cpuData_t   wrData;
		logic       cs0N;
		logic       cs3N;
		logic [3:0] dqmN;
		logic       rdN;
	} cpuBusReq_t;

	typedef struct packed {
		logic dramN;
		logic romN;
		logic sramN;
		logic smpcN;
	} dccSelect_t;

	typedef struct packed {
		logic       romN;
		logic       sramN;
		logic       ramlN;
		logic       ramhN;
		logic       stvIoN;
		logic [3:0] dqmN;
		logic       rdN;
	} memPort_t;

	typedef logic [2:0] aBusSel_t;
	typedef logic [2:0] bBusSel_t;

endpackage

`default_nettype wire

// File: source/saturnGlue_defs.svh
`ifndef SATURN_GLUE_DEFS_SVH
`define SATURN_GLUE_DEFS_SVH

// CPU bus and peripheral bus widths
`define CPU_ADDR_W      25
`define CPU_DATA_W      32
`define PBUS_DATA_W     16

// Read values with no slave selected
`define ABUS_IDLE_DATA  16'hFFFF
`define BBUS_IDLE_DATA  16'h0000

// ST-V board
`define STV_CART_MODE   3'd5
`define STV_IO_FIRST    25'h0400000
`define STV_IO_LAST     25'h040007F

// SMPC port 2 bits driving the ST-V sound resets
`define STV_SCSP_BIT    3
`define STV_SCPU_BIT    4

`endif
